//--- Makefile
VERILATOR := verilator
VFLAGS    := --binary --timing -Wno-fatal
TOP       := tb_fp_addsub
FILELIST  := src.f
BUILD_DIR := obj_dir

SIM     := $(BUILD_DIR)/V$(TOP)
SOURCES := $(shell grep -v '^+' $(FILELIST)) fp_cfg.svh tb_fp_model.svh

.PHONY: all run clean

all: $(SIM)

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: $(SIM)
	./$(SIM)

clean:
	rm -rf $(BUILD_DIR)

//--- fp_add.sv
`timescale 1ns/1ps

module fp_add (
   input  logic                clk,
   input  logic                reset,
   input  fp_pkg::fp_aligned_t aligned,
   output fp_pkg::fp_sum_t     sum
);

   logic [27:0] mag;

   // Operands arrive ordered, so the difference never goes negative
   always_comb begin
      if (aligned.eff_sub) mag = {1'b0, aligned.mant_l} - {1'b0, aligned.mant_s};
      else mag = {1'b0, aligned.mant_l} + {1'b0, aligned.mant_s};
   end

   always_ff @(posedge clk) begin
      sum.sign        <= aligned.sign;
      sum.exp         <= aligned.exp;
      sum.mag         <= mag;
      sum.special     <= aligned.special;
      sum.special_val <= aligned.special_val;
      sum.both_neg    <= aligned.both_neg;
      if (reset) sum.valid <= 1'b0;
      else sum.valid <= aligned.valid;
   end

endmodule

//--- fp_addsub_top.sv
`timescale 1ns/1ps

module fp_addsub_top (
   input  logic             clk,
   input  logic             reset,
   input  fp_pkg::apb_req_t apb_req,
   output fp_pkg::apb_rsp_t apb_rsp
);

   fp_pkg::fp_op_t      op;
   fp_pkg::fp_aligned_t aligned;
   fp_pkg::fp_sum_t     sum;
   fp_pkg::fp_result_t  res;
   fp_pkg::fp_result_t  fifo_head;
   logic                res_valid;
   logic                fifo_pop;
   logic [3:0]          fifo_count;

   fp_apb_regs u_regs (
      .clk        (clk),
      .reset      (reset),
      .apb_req    (apb_req),
      .apb_rsp    (apb_rsp),
      .op         (op),
      .fifo_head  (fifo_head),
      .fifo_count (fifo_count),
      .fifo_pop   (fifo_pop)
   );

   ////////////////////////////////////////
   // Three stage add/sub pipeline
   ////////////////////////////////////////
   fp_align u_align (.clk(clk), .reset(reset), .op(op), .aligned(aligned));

   fp_add u_add (.clk(clk), .reset(reset), .aligned(aligned), .sum(sum));

   fp_norm_round u_norm_round (
      .clk       (clk),
      .reset     (reset),
      .sum       (sum),
      .res_valid (res_valid),
      .res       (res)
   );

   fp_result_fifo u_fifo (
      .clk       (clk),
      .reset     (reset),
      .push      (res_valid),
      .push_data (res),
      .pop       (fifo_pop),
      .head      (fifo_head),
      .count     (fifo_count)
   );

endmodule

//--- fp_align.sv
`timescale 1ns/1ps
`include "fp_cfg.svh"

module fp_align (
   input  logic                clk,
   input  logic                reset,
   input  fp_pkg::fp_op_t      op,
   output fp_pkg::fp_aligned_t aligned
);

   fp_pkg::fp_word_u a_w;
   fp_pkg::fp_word_u b_w;
   logic        sa;
   logic        sb;
   logic [7:0]  ea;
   logic [7:0]  eb;
   logic [23:0] ma;
   logic [23:0] mb;
   logic        a_nan;
   logic        b_nan;
   logic        a_inf;
   logic        b_inf;
   logic        special;
   logic [31:0] special_val;
   logic        swap;
   logic [7:0]  exp_l;
   logic [7:0]  exp_s;
   logic [23:0] man_l;
   logic [23:0] man_s;
   logic [7:0]  diff;
   logic [4:0]  shamt;
   logic [57:0] wide;
   logic [57:0] shifted;
   logic        sticky;
   logic [26:0] man_s_al;

   assign a_w = op.a;
   assign b_w = op.b;

   assign sa = a_w.f.sign;
   assign sb = b_w.f.sign ^ op.sub; // Subtract is add with B negated

   // Subnormals sit at exponent 1 without the hidden bit
   assign ea = (a_w.f.exponent == 8'd0) ? 8'd1 : a_w.f.exponent;
   assign eb = (b_w.f.exponent == 8'd0) ? 8'd1 : b_w.f.exponent;
   assign ma = {a_w.f.exponent != 8'd0, a_w.f.mantissa};
   assign mb = {b_w.f.exponent != 8'd0, b_w.f.mantissa};

   ////////////////////////////////////////
   // Special operands
   ////////////////////////////////////////
   assign a_inf = (a_w.f.exponent == 8'hFF) && (a_w.f.mantissa == 23'd0);
   assign b_inf = (b_w.f.exponent == 8'hFF) && (b_w.f.mantissa == 23'd0);
   assign a_nan = (a_w.f.exponent == 8'hFF) && (a_w.f.mantissa != 23'd0);
   assign b_nan = (b_w.f.exponent == 8'hFF) && (b_w.f.mantissa != 23'd0);
   assign special = (a_w.f.exponent == 8'hFF) || (b_w.f.exponent == 8'hFF);

   always_comb begin
      if (a_nan || b_nan) special_val = `FP_QNAN;
      else if (a_inf && b_inf && (sa != sb)) special_val = `FP_QNAN; // inf - inf
      else if (a_inf) special_val = {sa, 8'hFF, 23'd0};
      else special_val = {sb, 8'hFF, 23'd0};
   end

   ////////////////////////////////////////
   // Order by magnitude and align
   ////////////////////////////////////////
   assign swap  = (eb > ea) || ((eb == ea) && (mb > ma));
   assign exp_l = swap ? eb : ea;
   assign exp_s = swap ? ea : eb;
   assign man_l = swap ? mb : ma;
   assign man_s = swap ? ma : mb;
   assign diff  = exp_l - exp_s;
   assign shamt = (diff > 8'd31) ? 5'd31 : diff[4:0];

   // Bits pushed below the guard bits end up in sticky
   assign wide     = {man_s, 3'b000, 31'd0};
   assign shifted  = wide >> shamt;
   assign sticky   = |shifted[30:0];
   assign man_s_al = {shifted[57:32], shifted[31] | sticky};

   always_ff @(posedge clk) begin
      aligned.sign        <= swap ? sb : sa;
      aligned.eff_sub     <= sa ^ sb;
      aligned.exp         <= exp_l;
      aligned.mant_l      <= {man_l, 3'b000};
      aligned.mant_s      <= man_s_al;
      aligned.special     <= special;
      aligned.special_val <= special_val;
      aligned.both_neg    <= sa & sb;
      if (reset) aligned.valid <= 1'b0;
      else aligned.valid <= op.valid;
   end

endmodule

//--- fp_apb_regs.sv
`timescale 1ns/1ps
`include "fp_cfg.svh"

module fp_apb_regs (
   input  logic               clk,
   input  logic               reset,
   input  fp_pkg::apb_req_t   apb_req,
   output fp_pkg::apb_rsp_t   apb_rsp,
   output fp_pkg::fp_op_t     op,
   input  fp_pkg::fp_result_t fifo_head,
   input  logic [3:0]         fifo_count,
   output logic               fifo_pop
);

   logic        access;
   logic        wr;
   logic        rd;
   logic [31:0] opa;
   logic [31:0] opb;
   logic [3:0]  credits;
   logic        credit_full;
   logic        fifo_empty;
   logic        issue;
   logic [31:0] status_word;
   logic [31:0] rdata;
   logic        err;

   assign access      = apb_req.psel & apb_req.penable; // Access phase always completes
   assign wr          = access & apb_req.pwrite;
   assign rd          = access & ~apb_req.pwrite;
   assign credit_full = (credits == 4'(`FP_FIFO_DEPTH));
   assign fifo_empty  = (fifo_count == 4'd0);

   // Head ovf only means something when an entry is there
   assign status_word = {23'b0, fifo_head.ovf & ~fifo_empty, 4'b0, fifo_count};

   ////////////////////////////////////////
   // Address decode and read mux
   ////////////////////////////////////////
   always_comb begin
      rdata    = '0;
      err      = 1'b0;
      issue    = 1'b0;
      fifo_pop = 1'b0;
      if (access) begin
         case (apb_req.paddr)
            `FP_ADDR_OPA: if (rd) rdata = opa;
            `FP_ADDR_OPB: if (rd) rdata = opb;
            `FP_ADDR_CMD: begin
               if (wr) begin
                  if (credit_full) err = 1'b1; // Every credit is taken
                  else issue = 1'b1;
               end
            end
            `FP_ADDR_RESULT: begin
               if (rd) begin
                  if (fifo_empty) begin
                     err = 1'b1;
                  end else begin
                     rdata    = fifo_head.value;
                     fifo_pop = 1'b1;
                  end
               end
            end
            `FP_ADDR_STATUS: if (rd) rdata = status_word;
            default: err = 1'b1;
         endcase
      end
   end

   assign apb_rsp.prdata  = rdata;
   assign apb_rsp.pready  = 1'b1;
   assign apb_rsp.pslverr = err;

   // The issued op enters stage 1 at the edge that ends this access
   assign op.valid = issue;
   assign op.a.raw = opa;
   assign op.b.raw = opb;
   assign op.sub   = apb_req.pwdata[0];

   always_ff @(posedge clk) begin
      if (reset) begin
         opa     <= '0;
         opb     <= '0;
         credits <= '0;
      end else begin
         if (wr && apb_req.paddr == `FP_ADDR_OPA) opa <= apb_req.pwdata;
         if (wr && apb_req.paddr == `FP_ADDR_OPB) opb <= apb_req.pwdata;
         // Credits cover ops in flight plus results not yet read
         credits <= credits + {3'b0, issue} - {3'b0, fifo_pop};
      end
   end

endmodule

//--- fp_cfg.svh
`ifndef FP_CFG_SVH
`define FP_CFG_SVH

////////////////////////////////////////
// Register map, byte offsets on APB
////////////////////////////////////////
`define FP_ADDR_OPA    8'h00
`define FP_ADDR_OPB    8'h04
`define FP_ADDR_CMD    8'h08
`define FP_ADDR_RESULT 8'h0C
`define FP_ADDR_STATUS 8'h10

// Result entries, also the cap on outstanding operations
`define FP_FIFO_DEPTH  8

// Every NaN result collapses to this quiet NaN
`define FP_QNAN        32'h7FC00000

`endif

//--- fp_norm_round.sv
`timescale 1ns/1ps
`include "fp_cfg.svh"

module fp_norm_round (
   input  logic               clk,
   input  logic               reset,
   input  fp_pkg::fp_sum_t    sum,
   output logic               res_valid,
   output fp_pkg::fp_result_t res
);

   logic [4:0]  lzc;
   logic [7:0]  exp_m1;
   logic [7:0]  shift;
   logic [26:0] norm;
   logic [8:0]  e_norm;
   logic        round_up;
   logic [24:0] rnd;
   logic [8:0]  e_out;
   logic        ovf_hit;
   logic        ovf;
   fp_pkg::fp_word_u word;

   ////////////////////////////////////////
   // Normalize
   ////////////////////////////////////////
   always_comb begin
      lzc = 5'd27;
      for (int i = 0; i < 27; i++) begin
         if (sum.mag[i]) lzc = 5'(26 - i); // Highest set bit wins
      end
   end

   assign exp_m1 = sum.exp - 8'd1;
   assign shift  = ({3'b0, lzc} > exp_m1) ? exp_m1 : {3'b0, lzc}; // Stop at subnormal level

   always_comb begin
      if (sum.mag[27]) begin
         norm   = {sum.mag[27:2], sum.mag[1] | sum.mag[0]};
         e_norm = {1'b0, sum.exp} + 9'd1;
      end else begin
         norm   = sum.mag[26:0] << shift;
         e_norm = {1'b0, sum.exp} - {1'b0, shift};
      end
   end

   ////////////////////////////////////////
   // Round to nearest even
   ////////////////////////////////////////
   assign round_up = norm[2] & (norm[1] | norm[0] | norm[3]);
   assign rnd      = {1'b0, norm[26:3]} + {24'd0, round_up};

   // A subnormal that rounds up into bit 23 already sits at exponent 1
   always_comb begin
      if (rnd[24]) e_out = e_norm + 9'd1;
      else if (rnd[23]) e_out = e_norm;
      else e_out = 9'd0;
   end

   assign ovf_hit = (e_out >= 9'd255);

   ////////////////////////////////////////
   // Pack
   ////////////////////////////////////////
   always_comb begin
      ovf = 1'b0;
      if (sum.special) begin
         word.raw = sum.special_val;
      end else if (sum.mag == 28'd0) begin
         word.f.sign     = sum.both_neg; // Exact zero is -0 only for -a + -b
         word.f.exponent = 8'd0;
         word.f.mantissa = 23'd0;
      end else if (ovf_hit) begin
         word.f.sign     = sum.sign;
         word.f.exponent = 8'hFF;
         word.f.mantissa = 23'd0;
         ovf             = 1'b1;
      end else begin
         word.f.sign     = sum.sign;
         word.f.exponent = e_out[7:0];
         word.f.mantissa = rnd[22:0];
      end
   end

   always_ff @(posedge clk) begin
      res.value <= word.raw;
      res.ovf   <= ovf;
      if (reset) res_valid <= 1'b0;
      else res_valid <= sum.valid;
   end

endmodule

//--- fp_pkg.sv
package fp_pkg;

   ////////////////////////////////////////
   // APB
   ////////////////////////////////////////
   typedef struct packed {
      logic [7:0]  paddr;
      logic        psel;
      logic        penable;
      logic        pwrite;
      logic [31:0] pwdata;
   } apb_req_t;

   typedef struct packed {
      logic [31:0] prdata;
      logic        pready;
      logic        pslverr;
   } apb_rsp_t;

   ////////////////////////////////////////
   // Float words and pipeline stages
   ////////////////////////////////////////
   typedef struct packed {
      logic        sign;
      logic [7:0]  exponent;
      logic [22:0] mantissa;
   } fp_fields_t;

   typedef union packed {
      logic [31:0] raw;
      fp_fields_t  f;
   } fp_word_u;

   typedef struct packed {
      logic     valid;
      fp_word_u a;
      fp_word_u b;
      logic     sub;
   } fp_op_t;

   typedef struct packed {
      logic        valid;
      logic        sign;        // Sign of the larger operand
      logic        eff_sub;
      logic [7:0]  exp;
      logic [26:0] mant_l;      // Hidden bit at 26, guard bits at 2:0
      logic [26:0] mant_s;      // Sticky folded into bit 0
      logic        special;
      logic [31:0] special_val;
      logic        both_neg;
   } fp_aligned_t;

   typedef struct packed {
      logic        valid;
      logic        sign;
      logic [7:0]  exp;
      logic [27:0] mag;         // Bit 27 is the carry out
      logic        special;
      logic [31:0] special_val;
      logic        both_neg;
   } fp_sum_t;

   typedef struct packed {
      logic [31:0] value;
      logic        ovf;
   } fp_result_t;

endpackage

//--- fp_result_fifo.sv
`timescale 1ns/1ps
`include "fp_cfg.svh"

module fp_result_fifo (
   input  logic               clk,
   input  logic               reset,
   input  logic               push,
   input  fp_pkg::fp_result_t push_data,
   input  logic               pop,
   output fp_pkg::fp_result_t head,
   output logic [3:0]         count
);

   fp_pkg::fp_result_t mem [`FP_FIFO_DEPTH];
   logic [$clog2(`FP_FIFO_DEPTH)-1:0] wr_ptr;
   logic [$clog2(`FP_FIFO_DEPTH)-1:0] rd_ptr;
   logic do_push;
   logic do_pop;

   assign do_push = push && (count != 4'(`FP_FIFO_DEPTH));
   assign do_pop  = pop && (count != 4'd0); // Pop on empty is dropped
   assign head    = mem[rd_ptr];

   always_ff @(posedge clk) begin
      if (do_push) mem[wr_ptr] <= push_data;
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (do_push) begin
            wr_ptr <= (wr_ptr == ($bits(wr_ptr))'(`FP_FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
         end
         if (do_pop) begin
            rd_ptr <= (rd_ptr == ($bits(rd_ptr))'(`FP_FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
         end
         count <= count + {3'b0, do_push} - {3'b0, do_pop};
      end
   end

endmodule

//--- src.f
+incdir+.
fp_pkg.sv
fp_apb_regs.sv
fp_align.sv
fp_add.sv
fp_norm_round.sv
fp_result_fifo.sv
fp_addsub_top.sv
tb_fp_addsub.sv

//--- tb_fp_model.svh
`ifndef TB_FP_MODEL_SVH
`define TB_FP_MODEL_SVH

// Reference single-precision add, returns {ovf, value}
function automatic logic [32:0] model_addsub(input logic [31:0] a, input logic [31:0] b,
                                             input logic sub);
   logic        sa;
   logic        sb;
   logic        sl;
   logic        a_nan;
   logic        b_nan;
   logic        a_inf;
   logic        b_inf;
   logic        up;
   logic [7:0]  ea;
   logic [7:0]  eb;
   logic [7:0]  el;
   logic [7:0]  e0;
   logic [23:0] ma;
   logic [23:0] mb;
   logic [23:0] ml;
   logic [23:0] ms;
   logic [79:0] big;
   logic [79:0] small_v;
   logic [79:0] mag;
   logic [79:0] q;
   logic [79:0] rem;
   logic [79:0] half;
   int          p;
   int          e_res;
   int          sh;

   sa    = a[31];
   sb    = b[31] ^ sub;
   a_inf = (a[30:23] == 8'hFF) && (a[22:0] == 23'd0);
   b_inf = (b[30:23] == 8'hFF) && (b[22:0] == 23'd0);
   a_nan = (a[30:23] == 8'hFF) && (a[22:0] != 23'd0);
   b_nan = (b[30:23] == 8'hFF) && (b[22:0] != 23'd0);
   if (a_nan || b_nan) return {1'b0, `FP_QNAN};
   if (a_inf && b_inf) return (sa != sb) ? {1'b0, `FP_QNAN} : {1'b0, sa, 8'hFF, 23'd0};
   if (a_inf) return {1'b0, sa, 8'hFF, 23'd0};
   if (b_inf) return {1'b0, sb, 8'hFF, 23'd0};

   ea = (a[30:23] == 8'd0) ? 8'd1 : a[30:23]; // Subnormals live at exponent 1
   eb = (b[30:23] == 8'd0) ? 8'd1 : b[30:23];
   ma = {a[30:23] != 8'd0, a[22:0]};
   mb = {b[30:23] != 8'd0, b[22:0]};
   if ({ea, ma} >= {eb, mb}) begin
      el = ea;
      e0 = eb;
      ml = ma;
      ms = mb;
      sl = sa;
   end else begin
      el = eb;
      e0 = ea;
      ml = mb;
      ms = ma;
      sl = sb;
   end

   // A far smaller operand only nudges the rounding, so one unit stands in for it
   if (el - e0 > 8'd40) begin
      big     = 80'(ml) << 40;
      small_v = (ms != 24'd0) ? 80'd1 : 80'd0;
      e0      = el - 8'd40;
   end else begin
      big     = 80'(ml) << (el - e0);
      small_v = 80'(ms);
   end
   mag = (sa == sb) ? big + small_v : big - small_v;
   if (mag == 80'd0) return {1'b0, sa & sb, 31'd0};

   p = 0;
   for (int i = 0; i < 80; i++) begin
      if (mag[i]) p = i;
   end
   e_res = int'(e0) + p - 23;
   if (e_res < 1) e_res = 1;
   sh = e_res - int'(e0);
   if (sh > 0) begin
      q    = mag >> sh;
      rem  = mag & ((80'd1 << sh) - 80'd1);
      half = 80'd1 << (sh - 1);
      up   = (rem > half) || ((rem == half) && q[0]); // Ties go to even
      q    = q + 80'(up);
   end else begin
      q = mag << (-sh);
   end
   if (q[24]) begin
      q     = q >> 1;
      e_res = e_res + 1;
   end
   if (e_res >= 255) return {1'b1, sl, 8'hFF, 23'd0};
   if (!q[23]) return {1'b0, sl, 8'd0, q[22:0]};
   return {1'b0, sl, 8'(e_res), q[22:0]};
endfunction

`endif

//--- tb_fp_addsub.sv
`timescale 1ns/1ps
`include "fp_cfg.svh"

module tb_fp_addsub;

   logic             clk;
   logic             reset;
   fp_pkg::apb_req_t apb_req;
   fp_pkg::apb_rsp_t apb_rsp;

   logic [31:0] exp_q [$]; // Expected results in issue order
   logic        ovf_q [$];
   int          n_issued = 0;
   int          cycles = 0;

   `include "tb_fp_model.svh"

   fp_addsub_top u_dut (
      .clk     (clk),
      .reset   (reset),
      .apb_req (apb_req),
      .apb_rsp (apb_rsp)
   );

   initial begin
      clk = 1'b0;
      forever #2 clk = ~clk;
   end

   // Every operation gets 200 cycles of budget
   always @(posedge clk) begin
      cycles <= cycles + 1;
      if (cycles > 200 * (n_issued + 1)) begin
         $display("FAIL: see errors above");
         $fatal(1, "timeout waiting for results");
      end
   end

   task automatic check_value(input string name, input logic [31:0] actual,
                              input logic [31:0] expected);
      if (actual !== expected) begin
         $display("[ERROR] %s: actual %h expected %h", name, actual, expected);
         $display("FAIL: see errors above");
         $fatal(1, "mismatch on %s", name);
      end
   endtask

   ////////////////////////////////////////
   // APB access, entered on a falling edge
   ////////////////////////////////////////
   task automatic apb_access(input logic wr, input logic [7:0] addr, input logic [31:0] wdata,
                             output logic [31:0] rdata, output logic err);
      apb_req.paddr   = addr;
      apb_req.pwrite  = wr;
      apb_req.pwdata  = wdata;
      apb_req.psel    = 1'b1;
      apb_req.penable = 1'b0;
      @(negedge clk);
      apb_req.penable = 1'b1;
      #1;
      rdata = apb_rsp.prdata; // Settled well before the rising edge
      err   = apb_rsp.pslverr;
      check_value("pready", {31'd0, apb_rsp.pready}, 32'd1);
      @(negedge clk);
      apb_req.psel    = 1'b0;
      apb_req.penable = 1'b0;
   endtask

   task automatic reg_write(input logic [7:0] addr, input logic [31:0] data, output logic err);
      logic [31:0] unused;
      apb_access(1'b1, addr, data, unused, err);
   endtask

   task automatic reg_read(input logic [7:0] addr, output logic [31:0] data, output logic err);
      apb_access(1'b0, addr, 32'd0, data, err);
   endtask

   function automatic logic [31:0] rand_operand();
      int unsigned sel;
      logic [31:0] r;
      sel = $urandom_range(99);
      r   = $urandom;
      if (sel < 70) return {r[31], 8'd120 + {4'd0, r[26:23]}, r[22:0]}; // Narrow range
      if (sel < 78) return {r[31], 31'd0};
      if (sel < 86) return {r[31], 8'd0, r[22:0]};
      if (sel < 92) return {r[31], 8'hFE - {7'd0, r[24]}, r[22:0]};
      if (sel < 96) return {r[31], 8'hFF, 23'd0};
      return {r[31], 8'hFF, r[22:0] | 23'd1};
   endfunction

   task automatic issue_cmd(input logic [31:0] a, input logic [31:0] b, input logic sub);
      logic        err;
      logic [32:0] m;
      reg_write(`FP_ADDR_CMD, {31'd0, sub}, err);
      check_value("cmd_pslverr", {31'd0, err}, 32'd0);
      m = model_addsub(a, b, sub);
      exp_q.push_back(m[31:0]);
      ovf_q.push_back(m[32]);
      n_issued++;
   endtask

   task automatic issue_op(input logic [31:0] a, input logic [31:0] b, input logic sub);
      logic err;
      reg_write(`FP_ADDR_OPA, a, err);
      reg_write(`FP_ADDR_OPB, b, err);
      issue_cmd(a, b, sub);
   endtask

   task automatic drain_one();
      logic [31:0] st;
      logic [31:0] val;
      logic        err;
      st = 32'd0;
      while (st[3:0] == 4'd0) reg_read(`FP_ADDR_STATUS, st, err);
      check_value("status_ovf", {31'd0, st[8]}, {31'd0, ovf_q.pop_front()});
      reg_read(`FP_ADDR_RESULT, val, err);
      check_value("result_pslverr", {31'd0, err}, 32'd0);
      check_value("result", val, exp_q.pop_front());
   endtask

   // Back-to-back commands, OPB sometimes rewritten in between
   task automatic run_burst(input int n);
      logic        err;
      logic [31:0] a;
      logic [31:0] b;
      a = rand_operand();
      b = rand_operand();
      reg_write(`FP_ADDR_OPA, a, err);
      reg_write(`FP_ADDR_OPB, b, err);
      for (int i = 0; i < n; i++) begin
         if ($urandom_range(1) == 1) begin
            b = rand_operand();
            reg_write(`FP_ADDR_OPB, b, err);
         end
         issue_cmd(a, b, 1'($urandom_range(1)));
      end
      repeat (n) drain_one();
   endtask

   initial begin
      logic [31:0] st;
      logic [31:0] rd;
      logic [31:0] a;
      logic [31:0] b;
      logic        err;
      int unsigned seed;

      apb_req = '0;
      reset   = 1'b1;
      seed    = $urandom(96138);
      repeat (8) @(posedge clk);
      @(negedge clk);
      reset = 1'b0;

      ////////////////////////////////////////
      // Register access
      ////////////////////////////////////////
      reg_read(`FP_ADDR_STATUS, st, err);
      check_value("status_reset", st, 32'd0);
      for (int i = 0; i < 4; i++) begin
         a = $urandom;
         b = $urandom;
         reg_write(`FP_ADDR_OPA, a, err);
         reg_write(`FP_ADDR_OPB, b, err);
         reg_read(`FP_ADDR_OPA, rd, err);
         check_value("opa", rd, a);
         reg_read(`FP_ADDR_OPB, rd, err);
         check_value("opb", rd, b);
      end

      // Single operations, some with nearly equal operands for cancellation
      for (int i = 0; i < 400; i++) begin
         a = rand_operand();
         b = ($urandom_range(9) == 0) ? {a[31:8], 8'($urandom)} : rand_operand();
         issue_op(a, b, 1'($urandom_range(1)));
         drain_one();
      end

      for (int i = 0; i < 30; i++) run_burst($urandom_range(`FP_FIFO_DEPTH, 1));

      ////////////////////////////////////////
      // Back-pressure and bus errors
      ////////////////////////////////////////
      for (int i = 0; i < `FP_FIFO_DEPTH; i++) issue_op(rand_operand(), rand_operand(), 1'b0);
      st = 32'd0;
      while (st[3:0] != 4'(`FP_FIFO_DEPTH)) reg_read(`FP_ADDR_STATUS, st, err);
      check_value("status_ovf", {31'd0, st[8]}, {31'd0, ovf_q.pop_front()});
      reg_write(`FP_ADDR_CMD, 32'd0, err);
      check_value("cmd_full_pslverr", {31'd0, err}, 32'd1);
      // Pop at once so a wrongly issued op would still find a free entry
      reg_read(`FP_ADDR_RESULT, rd, err);
      check_value("result_pslverr", {31'd0, err}, 32'd0);
      check_value("result", rd, exp_q.pop_front());
      repeat (4) @(negedge clk);
      reg_read(`FP_ADDR_STATUS, st, err);
      check_value("status_count", {28'd0, st[3:0]}, 32'(`FP_FIFO_DEPTH - 1));
      repeat (`FP_FIFO_DEPTH - 1) drain_one();
      reg_read(`FP_ADDR_STATUS, st, err);
      check_value("status_empty", st, 32'd0);
      reg_read(`FP_ADDR_RESULT, rd, err);
      check_value("empty_pslverr", {31'd0, err}, 32'd1);
      check_value("empty_prdata", rd, 32'd0);
      reg_read(8'h14, rd, err);
      check_value("unmapped_pslverr", {31'd0, err}, 32'd1);

      // Special cases against known answers
      check_value("model_inf_inf",
                  32'(model_addsub(32'h7F800000, 32'h7F800000, 1'b1)), 32'h7FC00000);
      check_value("model_max_ovf", 32'(model_addsub(32'h7F7FFFFF, 32'h7F7FFFFF, 1'b0) >> 32),
                  32'd1);
      check_value("model_sub_sum",
                  32'(model_addsub(32'h00000003, 32'h00400001, 1'b0)), 32'h00400004);
      issue_op(32'h7F800000, 32'h7F800000, 1'b1);
      issue_op(32'h7FC12345, 32'h3F800000, 1'b0);
      issue_op(32'h7F7FFFFF, 32'h7F7FFFFF, 1'b0);
      issue_op(32'h3FA00000, 32'h3FA00000, 1'b1);
      issue_op(32'h80000000, 32'h80000000, 1'b0);
      issue_op(32'h00000003, 32'h00400001, 1'b0);
      check_value("nan_expected", exp_q[1], `FP_QNAN);
      check_value("inf_expected", exp_q[2], 32'h7F800000);
      check_value("zero_expected", exp_q[3], 32'h00000000);
      check_value("neg_zero_expected", exp_q[4], 32'h80000000);
      repeat (6) drain_one();

      $display("PASS: all tests");
      $finish;
   end

endmodule
